// File: logic/mips_pkg.sv
////////////////////////////////////////
// MIPS subset shared definitions
// Word type, instruction views, encodings
////////////////////////////////////////
package mips_pkg;

  localparam int WORD_W = 32;

  typedef logic [WORD_W-1:0] word_t;

  // One instruction word, R and I field views
  typedef union packed {
    struct packed {
      logic [5:0] opcode;
      logic [4:0] rs;
      logic [4:0] rt;
      logic [4:0] rd;
      logic [4:0] shamt;
      logic [5:0] funct;
    } r;
    struct packed {
      logic [5:0]  opcode;
      logic [4:0]  rs;
      logic [4:0]  rt;
      logic [15:0] imm;
    } i;
  } instr_u;

  // Opcodes
  localparam logic [5:0] OP_RTYPE = 6'h00;
  localparam logic [5:0] OP_ADDIU = 6'h09;
  localparam logic [5:0] OP_ANDI  = 6'h0c;
  localparam logic [5:0] OP_ORI   = 6'h0d;
  localparam logic [5:0] OP_LUI   = 6'h0f;
  localparam logic [5:0] OP_LW    = 6'h23;
  localparam logic [5:0] OP_SW    = 6'h2b;

  // R-type funct codes
  localparam logic [5:0] FN_SLL  = 6'h00;
  localparam logic [5:0] FN_SRL  = 6'h02;
  localparam logic [5:0] FN_ADDU = 6'h21;
  localparam logic [5:0] FN_SUBU = 6'h23;
  localparam logic [5:0] FN_AND  = 6'h24;
  localparam logic [5:0] FN_OR   = 6'h25;
  localparam logic [5:0] FN_XOR  = 6'h26;
  localparam logic [5:0] FN_SLT  = 6'h2a;

  // ALU operations
  localparam logic [3:0] ALU_ADD = 4'd0;
  localparam logic [3:0] ALU_SUB = 4'd1;
  localparam logic [3:0] ALU_AND = 4'd2;
  localparam logic [3:0] ALU_OR  = 4'd3;
  localparam logic [3:0] ALU_XOR = 4'd4;
  localparam logic [3:0] ALU_SLT = 4'd5;
  localparam logic [3:0] ALU_SLL = 4'd6;
  localparam logic [3:0] ALU_SRL = 4'd7;
  localparam logic [3:0] ALU_LUI = 4'd8;

endpackage

// File: logic/inst_buffer.sv
////////////////////////////////////////
// Instruction FIFO ahead of decode
// Returns one credit per popped word
////////////////////////////////////////
`timescale 1ns/1ps

module inst_buffer import mips_pkg::*; #(
  parameter int IBUF_DEPTH = 4
) (
  input  logic  clk,
  input  logic  rst_n,
  input  logic  in_valid,
  input  word_t in_instr,
  input  logic  head_take,
  output logic  head_valid,
  output word_t head_instr,
  output logic  in_credit
);

  localparam int PW = (IBUF_DEPTH > 1) ? $clog2(IBUF_DEPTH) : 1;
  localparam int CW = $clog2(IBUF_DEPTH + 1);

  // Instruction word storage
  word_t mem [IBUF_DEPTH];

  logic [PW-1:0] wr_ptr;
  logic [PW-1:0] rd_ptr;
  logic [CW-1:0] count;
  logic          pop;

  // Pop only a valid head
  assign pop        = head_take & head_valid;
  assign head_valid = (count != '0);
  assign head_instr = mem[rd_ptr];
  // Credit goes back with the pop
  assign in_credit  = pop;

  always_ff @(posedge clk) begin
    if (in_valid) begin
      mem[wr_ptr] <= in_instr;
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      // Pointers wrap at the depth, not at a power of two
      if (in_valid) begin
        wr_ptr <= (wr_ptr == PW'(IBUF_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
      end
      if (pop) begin
        rd_ptr <= (rd_ptr == PW'(IBUF_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
      end
      // Occupancy
      case ({in_valid, pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

endmodule

// File: logic/decode_stage.sv
////////////////////////////////////////
// Decode stage with register file
// Field decode, controls, load-use stall
////////////////////////////////////////
`timescale 1ns/1ps

module decode_stage import mips_pkg::*; (
  input  logic       clk,
  input  logic       rst_n,
  input  logic       head_valid,
  input  word_t      head_instr,
  input  logic       ex_read_mem,
  input  logic [4:0] ex_rt,
  input  logic       wb_valid,
  input  logic [4:0] wb_reg,
  input  word_t      wb_data,
  output logic       head_take,
  output logic       bubble,
  output logic       id_valid,
  output word_t      id_bus_a,
  output word_t      id_bus_b,
  output word_t      id_imm32,
  output logic [4:0] id_rs,
  output logic [4:0] id_rt,
  output logic [4:0] id_dst,
  output logic [3:0] id_alu_op,
  output logic       id_alu_src_imm,
  output logic       id_reg_write,
  output logic       id_read_mem,
  output logic       id_mem_write
);

  instr_u     ins;
  word_t      regs [32];
  logic [4:0] dst;
  logic       stall;
  logic       use_rs;
  logic       use_rt;
  logic       imm_zext;
  logic       wr;
  logic       rd_mem;
  logic       wr_mem;

  assign ins = head_instr;

  ////////////////////////////////////////
  // Register file
  ////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      for (int k = 0; k < 32; k++) begin
        regs[k] <= '0;
      end
    end else if (wb_valid && wb_reg != 5'd0) begin
      regs[wb_reg] <= wb_data;
    end
  end

  // Read with WB bypass, r0 stays zero
  function automatic word_t read_reg(input logic [4:0] idx);
    if (idx == 5'd0) begin
      return '0;
    end
    if (wb_valid && wb_reg == idx) begin
      return wb_data;
    end
    return regs[idx];
  endfunction

  ////////////////////////////////////////
  // Opcode and funct decode
  ////////////////////////////////////////

  always_comb begin
    id_alu_op      = ALU_ADD;
    id_alu_src_imm = 1'b1;
    imm_zext       = 1'b0;
    use_rs         = 1'b1;
    use_rt         = 1'b0;
    wr             = 1'b0;
    rd_mem         = 1'b0;
    wr_mem         = 1'b0;
    // I-type writes rt
    dst            = ins.i.rt;
    case (ins.r.opcode)
      OP_RTYPE: begin
        id_alu_src_imm = 1'b0;
        use_rt         = 1'b1;
        dst            = ins.r.rd;
        wr             = 1'b1;
        case (ins.r.funct)
          FN_ADDU: id_alu_op = ALU_ADD;
          FN_SUBU: id_alu_op = ALU_SUB;
          FN_AND:  id_alu_op = ALU_AND;
          FN_OR:   id_alu_op = ALU_OR;
          FN_XOR:  id_alu_op = ALU_XOR;
          FN_SLT:  id_alu_op = ALU_SLT;
          // Shifts take rt and shamt only
          FN_SLL: begin
            id_alu_op = ALU_SLL;
            use_rs    = 1'b0;
          end
          FN_SRL: begin
            id_alu_op = ALU_SRL;
            use_rs    = 1'b0;
          end
          default: wr = 1'b0;
        endcase
      end
      OP_ADDIU: wr = 1'b1;
      OP_ANDI: begin
        id_alu_op = ALU_AND;
        imm_zext  = 1'b1;
        wr        = 1'b1;
      end
      OP_ORI: begin
        id_alu_op = ALU_OR;
        imm_zext  = 1'b1;
        wr        = 1'b1;
      end
      OP_LUI: begin
        id_alu_op = ALU_LUI;
        use_rs    = 1'b0;
        wr        = 1'b1;
      end
      OP_LW: begin
        rd_mem = 1'b1;
        wr     = 1'b1;
      end
      OP_SW: begin
        wr_mem = 1'b1;
        use_rt = 1'b1;
      end
      // Unknown opcode runs as a NOP
      default: use_rs = 1'b0;
    endcase
  end

  assign id_rs    = ins.r.rs;
  assign id_rt    = ins.i.rt;
  assign id_dst   = dst;
  assign id_imm32 = imm_zext ? {16'b0, ins.i.imm} : {{16{ins.i.imm[15]}}, ins.i.imm};
  assign id_bus_a = read_reg(ins.r.rs);
  assign id_bus_b = read_reg(ins.i.rt);

  // Enables only for a real head, never for r0
  assign id_valid     = head_valid;
  assign id_reg_write = head_valid & wr & (dst != 5'd0);
  assign id_read_mem  = head_valid & rd_mem;
  assign id_mem_write = head_valid & wr_mem;

  // Load in EX feeding a source used here
  assign stall = head_valid & ex_read_mem & (ex_rt != 5'd0) &
                 ((use_rs & (ex_rt == ins.r.rs)) | (use_rt & (ex_rt == ins.i.rt)));

  assign bubble    = stall;
  assign head_take = head_valid & ~stall;

endmodule

// File: logic/idex_reg.sv
////////////////////////////////////////
// ID/EX pipeline register
// Bubble loaded on a load-use stall
////////////////////////////////////////
`timescale 1ns/1ps

module idex_reg import mips_pkg::*; (
  input  logic       clk,
  input  logic       rst_n,
  input  logic       bubble,
  input  logic       id_valid,
  input  word_t      id_bus_a,
  input  word_t      id_bus_b,
  input  word_t      id_imm32,
  input  logic [4:0] id_rs,
  input  logic [4:0] id_rt,
  input  logic [4:0] id_dst,
  input  logic [3:0] id_alu_op,
  input  logic       id_alu_src_imm,
  input  logic       id_reg_write,
  input  logic       id_read_mem,
  input  logic       id_mem_write,
  output logic       ex_valid,
  output word_t      ex_bus_a,
  output word_t      ex_bus_b,
  output word_t      ex_imm32,
  output logic [4:0] ex_rs,
  output logic [4:0] ex_rt,
  output logic [4:0] ex_dst,
  output logic [4:0] ex_shamt,
  output logic [3:0] ex_alu_op,
  output logic       ex_alu_src_imm,
  output logic       ex_reg_write,
  output logic       ex_read_mem,
  output logic       ex_mem_write
);

  // Operands and fields
  always_ff @(posedge clk) begin
    ex_bus_a       <= id_bus_a;
    ex_bus_b       <= id_bus_b;
    ex_imm32       <= id_imm32;
    ex_rs          <= id_rs;
    ex_rt          <= id_rt;
    ex_dst         <= id_dst;
    ex_alu_src_imm <= id_alu_src_imm;
    // Shift amount sits in imm bits 10:6
    ex_shamt       <= id_imm32[10:6];
  end

  // Control, cleared by reset or bubble
  always_ff @(posedge clk) begin
    if (!rst_n || bubble) begin
      ex_valid     <= 1'b0;
      ex_alu_op    <= ALU_ADD;
      ex_reg_write <= 1'b0;
      ex_read_mem  <= 1'b0;
      ex_mem_write <= 1'b0;
    end else begin
      ex_valid     <= id_valid;
      ex_alu_op    <= id_alu_op;
      ex_reg_write <= id_reg_write;
      ex_read_mem  <= id_read_mem;
      ex_mem_write <= id_mem_write;
    end
  end

endmodule

// File: logic/execute_stage.sv
////////////////////////////////////////
// Execute stage
// Operand forwarding and ALU
////////////////////////////////////////
`timescale 1ns/1ps

module execute_stage import mips_pkg::*; (
  input  logic       clk,
  input  logic       rst_n,
  input  logic       ex_valid,
  input  word_t      ex_bus_a,
  input  word_t      ex_bus_b,
  input  word_t      ex_imm32,
  input  logic [4:0] ex_rs,
  input  logic [4:0] ex_rt,
  input  logic [4:0] ex_dst,
  input  logic [4:0] ex_shamt,
  input  logic [3:0] ex_alu_op,
  input  logic       ex_alu_src_imm,
  input  logic       ex_reg_write,
  input  logic       ex_read_mem,
  input  logic       ex_mem_write,
  input  logic       mem_reg_write,
  input  logic [4:0] mem_dst,
  input  word_t      mem_result,
  input  logic       wb_valid,
  input  logic [4:0] wb_reg,
  input  word_t      wb_data,
  output word_t      alu_result,
  output word_t      store_data,
  output logic [4:0] dst,
  output logic       reg_write,
  output logic       mem_read,
  output logic       mem_write
);

  word_t fwd_a;
  word_t fwd_b;
  word_t op_b;

  // MEM result first, then WB, then register value
  function automatic word_t forward(input logic [4:0] src, input word_t reg_val);
    if (src == 5'd0) begin
      return reg_val;
    end
    if (mem_reg_write && mem_dst == src) begin
      return mem_result;
    end
    if (wb_valid && wb_reg == src) begin
      return wb_data;
    end
    return reg_val;
  endfunction

  assign fwd_a = forward(ex_rs, ex_bus_a);
  assign fwd_b = forward(ex_rt, ex_bus_b);
  assign op_b  = ex_alu_src_imm ? ex_imm32 : fwd_b;

  ////////////////////////////////////////
  // ALU
  ////////////////////////////////////////

  always_comb begin
    case (ex_alu_op)
      ALU_ADD: alu_result = fwd_a + op_b;
      ALU_SUB: alu_result = fwd_a - op_b;
      ALU_AND: alu_result = fwd_a & op_b;
      ALU_OR:  alu_result = fwd_a | op_b;
      ALU_XOR: alu_result = fwd_a ^ op_b;
      // Signed compare
      ALU_SLT: alu_result = {31'b0, $signed(fwd_a) < $signed(op_b)};
      ALU_SLL: alu_result = op_b << ex_shamt;
      ALU_SRL: alu_result = op_b >> ex_shamt;
      ALU_LUI: alu_result = {op_b[15:0], 16'b0};
      default: alu_result = '0;
    endcase
  end

  // SW stores the forwarded rt
  assign store_data = fwd_b;
  assign dst        = ex_dst;
  assign reg_write  = ex_valid & ex_reg_write;
  assign mem_read   = ex_valid & ex_read_mem;
  assign mem_write  = ex_valid & ex_mem_write;

endmodule

// File: logic/mem_wb_stage.sv
////////////////////////////////////////
// Memory and writeback stages
// EX/MEM register, data RAM, MEM/WB register
////////////////////////////////////////
`timescale 1ns/1ps

module mem_wb_stage import mips_pkg::*; #(
  parameter int DMEM_WORDS = 64
) (
  input  logic       clk,
  input  logic       rst_n,
  input  word_t      alu_result,
  input  word_t      store_data,
  input  logic [4:0] dst,
  input  logic       reg_write,
  input  logic       mem_read,
  input  logic       mem_write,
  output logic       mem_reg_write,
  output logic [4:0] mem_dst,
  output word_t      mem_result,
  output logic       wb_valid,
  output logic [4:0] wb_reg,
  output word_t      wb_data
);

  localparam int AW = (DMEM_WORDS > 1) ? $clog2(DMEM_WORDS) : 1;

  word_t ram [DMEM_WORDS];
  word_t m_alu;
  logic  m_read;

  ////////////////////////////////////////
  // EX/MEM register and RAM write
  ////////////////////////////////////////

  always_ff @(posedge clk) begin
    m_alu   <= alu_result;
    mem_dst <= dst;
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      mem_reg_write <= 1'b0;
      m_read        <= 1'b0;
    end else begin
      mem_reg_write <= reg_write;
      m_read        <= mem_read;
    end
  end

  // Word address from the byte address
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      for (int k = 0; k < DMEM_WORDS; k++) begin
        ram[k] <= '0;
      end
    end else if (mem_write) begin
      ram[alu_result[AW+1:2]] <= store_data;
    end
  end

  // Load data read in MEM
  assign mem_result = m_read ? ram[m_alu[AW+1:2]] : m_alu;

  ////////////////////////////////////////
  // MEM/WB register
  ////////////////////////////////////////

  always_ff @(posedge clk) begin
    wb_reg  <= mem_dst;
    wb_data <= mem_result;
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      wb_valid <= 1'b0;
    end else begin
      wb_valid <= mem_reg_write;
    end
  end

endmodule

// File: logic/mips_core.sv
////////////////////////////////////////
// MIPS subset integer pipeline top
////////////////////////////////////////
`timescale 1ns/1ps

module mips_core import mips_pkg::*; #(
  parameter int IBUF_DEPTH = 4,
  parameter int DMEM_WORDS = 64
) (
  input  logic       clk,
  input  logic       rst_n,
  input  logic       in_valid,
  input  word_t      in_instr,
  output logic       in_credit,
  output logic       wb_valid,
  output logic [4:0] wb_reg,
  output word_t      wb_data
);

  // Buffer to decode
  logic       head_valid;
  word_t      head_instr;
  logic       head_take;

  // Decode to ID/EX
  logic       bubble;
  logic       id_valid;
  word_t      id_bus_a;
  word_t      id_bus_b;
  word_t      id_imm32;
  logic [4:0] id_rs;
  logic [4:0] id_rt;
  logic [4:0] id_dst;
  logic [3:0] id_alu_op;
  logic       id_alu_src_imm;
  logic       id_reg_write;
  logic       id_read_mem;
  logic       id_mem_write;

  // ID/EX to execute
  logic       ex_valid;
  word_t      ex_bus_a;
  word_t      ex_bus_b;
  word_t      ex_imm32;
  logic [4:0] ex_rs;
  logic [4:0] ex_rt;
  logic [4:0] ex_dst;
  logic [4:0] ex_shamt;
  logic [3:0] ex_alu_op;
  logic       ex_alu_src_imm;
  logic       ex_reg_write;
  logic       ex_read_mem;
  logic       ex_mem_write;

  // Execute to memory
  word_t      alu_result;
  word_t      store_data;
  logic [4:0] dst;
  logic       reg_write;
  logic       mem_read;
  logic       mem_write;

  // MEM forwarding path
  logic       mem_reg_write;
  logic [4:0] mem_dst;
  word_t      mem_result;

  inst_buffer #(
    .IBUF_DEPTH(IBUF_DEPTH)
  ) u_ibuf (
    .clk       (clk),
    .rst_n     (rst_n),
    .in_valid  (in_valid),
    .in_instr  (in_instr),
    .head_take (head_take),
    .head_valid(head_valid),
    .head_instr(head_instr),
    .in_credit (in_credit)
  );

  decode_stage u_decode (
    .clk           (clk),
    .rst_n         (rst_n),
    .head_valid    (head_valid),
    .head_instr    (head_instr),
    .ex_read_mem   (ex_read_mem),
    .ex_rt         (ex_rt),
    .wb_valid      (wb_valid),
    .wb_reg        (wb_reg),
    .wb_data       (wb_data),
    .head_take     (head_take),
    .bubble        (bubble),
    .id_valid      (id_valid),
    .id_bus_a      (id_bus_a),
    .id_bus_b      (id_bus_b),
    .id_imm32      (id_imm32),
    .id_rs         (id_rs),
    .id_rt         (id_rt),
    .id_dst        (id_dst),
    .id_alu_op     (id_alu_op),
    .id_alu_src_imm(id_alu_src_imm),
    .id_reg_write  (id_reg_write),
    .id_read_mem   (id_read_mem),
    .id_mem_write  (id_mem_write)
  );

  idex_reg u_idex (
    .clk           (clk),
    .rst_n         (rst_n),
    .bubble        (bubble),
    .id_valid      (id_valid),
    .id_bus_a      (id_bus_a),
    .id_bus_b      (id_bus_b),
    .id_imm32      (id_imm32),
    .id_rs         (id_rs),
    .id_rt         (id_rt),
    .id_dst        (id_dst),
    .id_alu_op     (id_alu_op),
    .id_alu_src_imm(id_alu_src_imm),
    .id_reg_write  (id_reg_write),
    .id_read_mem   (id_read_mem),
    .id_mem_write  (id_mem_write),
    .ex_valid      (ex_valid),
    .ex_bus_a      (ex_bus_a),
    .ex_bus_b      (ex_bus_b),
    .ex_imm32      (ex_imm32),
    .ex_rs         (ex_rs),
    .ex_rt         (ex_rt),
    .ex_dst        (ex_dst),
    .ex_shamt      (ex_shamt),
    .ex_alu_op     (ex_alu_op),
    .ex_alu_src_imm(ex_alu_src_imm),
    .ex_reg_write  (ex_reg_write),
    .ex_read_mem   (ex_read_mem),
    .ex_mem_write  (ex_mem_write)
  );

  execute_stage u_exec (
    .clk           (clk),
    .rst_n         (rst_n),
    .ex_valid      (ex_valid),
    .ex_bus_a      (ex_bus_a),
    .ex_bus_b      (ex_bus_b),
    .ex_imm32      (ex_imm32),
    .ex_rs         (ex_rs),
    .ex_rt         (ex_rt),
    .ex_dst        (ex_dst),
    .ex_shamt      (ex_shamt),
    .ex_alu_op     (ex_alu_op),
    .ex_alu_src_imm(ex_alu_src_imm),
    .ex_reg_write  (ex_reg_write),
    .ex_read_mem   (ex_read_mem),
    .ex_mem_write  (ex_mem_write),
    .mem_reg_write (mem_reg_write),
    .mem_dst       (mem_dst),
    .mem_result    (mem_result),
    .wb_valid      (wb_valid),
    .wb_reg        (wb_reg),
    .wb_data       (wb_data),
    .alu_result    (alu_result),
    .store_data    (store_data),
    .dst           (dst),
    .reg_write     (reg_write),
    .mem_read      (mem_read),
    .mem_write     (mem_write)
  );

  mem_wb_stage #(
    .DMEM_WORDS(DMEM_WORDS)
  ) u_memwb (
    .clk          (clk),
    .rst_n        (rst_n),
    .alu_result   (alu_result),
    .store_data   (store_data),
    .dst          (dst),
    .reg_write    (reg_write),
    .mem_read     (mem_read),
    .mem_write    (mem_write),
    .mem_reg_write(mem_reg_write),
    .mem_dst      (mem_dst),
    .mem_result   (mem_result),
    .wb_valid     (wb_valid),
    .wb_reg       (wb_reg),
    .wb_data      (wb_data)
  );

endmodule

// File: test/mips_core_properties.sv
////////////////////////////////////////
// Credit and writeback assertions
////////////////////////////////////////
`timescale 1ns/1ps

module mips_core_properties #(
  parameter int IBUF_DEPTH = 4
) (
  input logic                             clk,
  input logic                             rst_n,
  input logic                             in_valid,
  input logic                             in_credit,
  input logic                             wb_valid,
  input logic [4:0]                       wb_reg,
  input logic [$clog2(IBUF_DEPTH+1)-1:0] ibuf_count
);

  // Number of assertion failures so far
  int unsigned failures = 0;

  // Full buffer takes a word only in the cycle it pops one
  a_no_overflow: assert property (@(posedge clk) disable iff (!rst_n)
    in_valid |-> (ibuf_count < IBUF_DEPTH) || in_credit)
    else begin
      failures++;
      $error("in_valid sent with no credit left");
    end

  // r0 never written back
  a_wb_nonzero: assert property (@(posedge clk) disable iff (!rst_n)
    wb_valid |-> wb_reg != 5'd0)
    else begin
      failures++;
      $error("writeback to register 0");
    end

  a_quiet_after_reset: assert property (@(posedge clk)
    $rose(rst_n) |-> !in_credit && !wb_valid)
    else begin
      failures++;
      $error("in_credit or wb_valid high right after reset");
    end

endmodule

bind mips_core mips_core_properties #(
  .IBUF_DEPTH(IBUF_DEPTH)
) u_props (
  .clk       (clk),
  .rst_n     (rst_n),
  .in_valid  (in_valid),
  .in_credit (in_credit),
  .wb_valid  (wb_valid),
  .wb_reg    (wb_reg),
  .ibuf_count(u_ibuf.count)
);

// File: test/mips_core_tb.sv
////////////////////////////////////////
// MIPS core testbench
// File-driven instruction stream, in-order writeback checks
////////////////////////////////////////
`timescale 1ns/1ps

module mips_core_tb import mips_pkg::*; ();

  localparam int IBUF_DEPTH   = 4;
  localparam int CREDIT_LIMIT = 200;
  localparam int DRAIN_LIMIT  = 500;

  logic       clk;
  logic       rst_n;
  logic       in_valid;
  word_t      in_instr;
  logic       in_credit;
  logic       wb_valid;
  logic [4:0] wb_reg;
  word_t      wb_data;

  // Instructions to send, expected writebacks in program order
  word_t      instr_q[$];
  logic [4:0] exp_reg_q[$];
  word_t      exp_data_q[$];

  // Sender credit model
  int credits;
  int sent;
  int returned;

  mips_core u_dut (
    .clk      (clk),
    .rst_n    (rst_n),
    .in_valid (in_valid),
    .in_instr (in_instr),
    .in_credit(in_credit),
    .wb_valid (wb_valid),
    .wb_reg   (wb_reg),
    .wb_data  (wb_data)
  );

  always #5 clk = ~clk;

  task automatic stop_on_error();
    $display("*** FAILED ***");
    $fatal(1, "run stopped at first error");
  endtask

  task automatic check_reg(input string name, input logic [4:0] got, input logic [4:0] exp);
    if (got !== exp) begin
      $display("CHECK FAILED %s got %h expected %h", name, got, exp);
      stop_on_error();
    end
  endtask

  task automatic check_word(input string name, input word_t got, input word_t exp);
    if (got !== exp) begin
      $display("CHECK FAILED %s got %h expected %h", name, got, exp);
      stop_on_error();
    end
  endtask

  ////////////////////////////////////////
  // Data file
  ////////////////////////////////////////

  task automatic load_tests();
    int    fd;
    int    code;
    int    reg_num;
    word_t value;
    string line;
    fd = $fopen("test/mips_core_tests.dat", "r");
    if (fd == 0) begin
      $display("Could not open the test data file");
      stop_on_error();
    end
    while (!$feof(fd)) begin
      line = "";
      code = $fgets(line, fd);
      // Comments and blank lines skipped
      if (code > 0 && line.getc(0) == "I") begin
        code = $sscanf(line, "I %h", value);
        if (code != 1) begin
          $display("Malformed instruction line in the test data file");
          stop_on_error();
        end
        instr_q.push_back(value);
      end else if (code > 0 && line.getc(0) == "W") begin
        code = $sscanf(line, "W %d %h", reg_num, value);
        if (code != 2) begin
          $display("Malformed writeback line in the test data file");
          stop_on_error();
        end
        exp_reg_q.push_back(reg_num[4:0]);
        exp_data_q.push_back(value);
      end
    end
    $fclose(fd);
  endtask

  ////////////////////////////////////////
  // Cycle, sample and send
  ////////////////////////////////////////

  // Sample at the falling edge, then drop the send strobe
  task automatic next_cycle();
    @(negedge clk);
    if (in_credit) begin
      credits++;
      returned++;
    end
    if (wb_valid) begin
      if (exp_reg_q.size() == 0) begin
        $display("Writeback to register %0d arrived with none expected", wb_reg);
        stop_on_error();
      end else begin
        check_reg("wb_reg", wb_reg, exp_reg_q.pop_front());
        check_word("wb_data", wb_data, exp_data_q.pop_front());
      end
    end
    in_valid = 1'b0;
    in_instr = '0;
  endtask

  task automatic send_instr(input word_t instr);
    int waited;
    waited = 0;
    next_cycle();
    // No credit, no send
    while (credits == 0) begin
      if (waited == CREDIT_LIMIT) begin
        $display("Timed out waiting for a credit from the core");
        stop_on_error();
      end
      next_cycle();
      waited++;
    end
    in_valid = 1'b1;
    in_instr = instr;
    credits--;
    sent++;
  endtask

  initial begin
    int gap;
    int waited;
    clk      = 1'b0;
    rst_n    = 1'b0;
    in_valid = 1'b0;
    in_instr = '0;
    credits  = IBUF_DEPTH;
    sent     = 0;
    returned = 0;
    void'($urandom(51229));
    load_tests();
    if (instr_q.size() == 0) begin
      $display("Test data file holds no instructions");
      stop_on_error();
    end

    // Two reset cycles
    repeat (2) @(posedge clk);
    @(negedge clk);
    rst_n = 1'b1;

    // Bursts with the odd idle gap
    while (instr_q.size() > 0) begin
      gap = ($urandom % 4 == 0) ? $urandom % 5 : 0;
      repeat (gap) next_cycle();
      send_instr(instr_q.pop_front());
    end

    // Drain until all writebacks seen and credits home
    waited = 0;
    while (exp_reg_q.size() > 0 || credits != IBUF_DEPTH) begin
      if (waited == DRAIN_LIMIT) begin
        $display("Timed out draining, %0d writebacks missing, %0d credits held",
                 exp_reg_q.size(), credits);
        stop_on_error();
      end
      next_cycle();
      waited++;
    end
    // Quiet cycles catch stray writebacks or credits
    repeat (6) next_cycle();

    if (u_dut.u_props.failures != 0) begin
      $display("Bound assertions failed %0d times during the run",
               u_dut.u_props.failures);
      stop_on_error();
    end

    if (exp_reg_q.size() == 0 && credits == IBUF_DEPTH && returned == sent) begin
      $display("*** PASSED ***");
    end else begin
      $display("Credit mismatch, %0d credits, %0d sent, %0d returned",
               credits, sent, returned);
      stop_on_error();
    end
    $finish;
  end

endmodule

// File: test/mips_core_tests.dat
# I <instruction word hex>
# W <destination register decimal> <expected writeback data hex>
I 24010005
W 1 00000005
I 2402fffd
W 2 fffffffd
I 00221821
W 3 00000002
I 00612023
W 4 fffffffd
I 0081282a
W 5 00000001
I 0024302a
W 6 00000000
I 3c071234
W 7 12340000
I 34e7abcd
W 7 1234abcd
I 30e8ff0f
W 8 0000ab0d
I 00e24826
W 9 edcb5430
I 01215025
W 10 edcb5435
I 00ea5824
W 11 00000005
I 00016100
W 12 00000050
I 00026a02
W 13 00ffffff
I 24200007
I 00017021
W 14 00000005
I ac070008
I 8c0f0008
W 15 1234abcd
I 25f00001
W 16 1234abce

// File: compile.f
logic/mips_pkg.sv
logic/inst_buffer.sv
logic/decode_stage.sv
logic/idex_reg.sv
logic/execute_stage.sv
logic/mem_wb_stage.sv
logic/mips_core.sv
test/mips_core_properties.sv
test/mips_core_tb.sv
